// File: bank_fill.f
+incdir+src
src/lfill_pkg.sv
src/bank_isu_inflight_array.sv
src/fill_requester.sv
src/fill_arbiter.sv
src/fill_biu.sv
src/bank_fill_top.sv
verification/bank_fill_chk.sv
verification/bank_fill_tb.sv

// File: Bender.yml
package:
  name: bank_fill

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lfill_pkg.sv
      - src/bank_isu_inflight_array.sv
      - src/fill_requester.sv
      - src/fill_arbiter.sv
      - src/fill_biu.sv
      - src/bank_fill_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/bank_fill_chk.sv
      - verification/bank_fill_tb.sv

// File: verification/bank_fill_tb.sv
`include "lfill_params.svh"

module bank_fill_tb import lfill_pkg::*; ();

  localparam int LAT        = `LFILL_BIU_LATENCY;
  localparam int NUM_TESTS  = 5;
  localparam int MAX_CYCLES = NUM_TESTS * (LAT + 6) + 8 + 40;  // Reset plus margin

  logic                                clk;
  logic                                rst;
  miss_t        [`LFILL_NUM_REQ-1:0]   miss;
  logic         [`LFILL_NUM_REQ-1:0]   miss_ready;
  logic         [`LFILL_NUM_REQ-1:0]   done;
  fill_status_e [`LFILL_NUM_REQ-1:0]   done_status;
  int                                  cycle;
  int                                  errors;
  int                                  tests_run;
  int                                  tests_failed;
  logic [31:0]                         lfsr_q;

  bank_fill_top dut_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .miss_i        (miss),
    .miss_ready_o  (miss_ready),
    .done_o        (done),
    .done_status_o (done_status)
  );

  bind bank_fill_top bank_fill_chk u_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .miss_ready_i (miss_ready_o),
    .done_i       (done_o),
    .grant_i      (grant),
    .state_i      ({gen_req[1].u_req.state_q, gen_req[0].u_req.state_q}),
    .cmd_i        (cmd),
    .rsp_i        (rsp),
    .inflight_q_i (u_array.inflight_q)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a done pulse never arrived", cycle);
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] take_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int error_total();
    return errors + dut_i.u_chk.fail_cnt;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (error_total() != errs_before) tests_failed++;
    $display("Test %0d %s: %s", tests_run, name, (error_total() == errs_before) ? "pass" : "fail");
  endtask

  // Called on a falling edge; start and done are cycle numbers
  task automatic run_miss(input int n, input int lead, input set_idx_t s, input way_idx_t w,
                          input fill_status_e exp, output int start_cyc, output int done_cyc);
    repeat (lead) @(negedge clk);
    start_cyc = cycle;
    miss[n] = '{valid: 1'b1, set: s, way: w};
    @(negedge clk);
    miss[n].valid = 1'b0;
    while (!done[n]) begin
      if (miss_ready[n]) begin
        $display("Requester %0d became ready again before its done pulse", n);
        errors++;
      end
      @(negedge clk);
    end
    done_cyc = cycle;
    check_val($sformatf("done_status_o[%0d]", n), done_status[n], exp);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    set_idx_t s0, s1, rep_s;
    way_idx_t w0, w1, rep_w;
    int       st[2];
    int       dn[2];
    int       e0;
    int       first;
    int       last_grant;

    clk = 1'b0;
    rst = 1'b1;
    miss = '0;
    cycle = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr_q = 32'h3a0a;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e0 = error_total();
    check_val("miss_ready_o", miss_ready, 2'b11);
    check_val("done_o", done, 2'b00);
    close_test("after reset", e0);

    e0 = error_total();
    rep_s = set_idx_t'(take_bits(3));
    rep_w = way_idx_t'(take_bits(3));
    run_miss(0, 0, rep_s, rep_w, FILL_ISSUED, st[0], dn[0]);
    check_val("done_o[0] latency", dn[0] - st[0], LAT + 2);
    last_grant = 0;
    close_test("single miss", e0);

    repeat (2) @(negedge clk);
    e0 = error_total();
    s0 = set_idx_t'(take_bits(3));
    w0 = way_idx_t'(take_bits(3));
    fork
      run_miss(0, 0, s0, w0, FILL_ISSUED, st[0], dn[0]);
      run_miss(1, 1, s0, w0, FILL_MERGED, st[1], dn[1]);  // One cycle behind
    join
    check_val("done_o[0] latency", dn[0] - st[0], LAT + 2);
    check_val("done_o[1] cycle", dn[1], dn[0]);
    last_grant = 1;
    close_test("same line merge", e0);

    repeat (2) @(negedge clk);
    e0 = error_total();
    s0 = set_idx_t'(take_bits(3));
    w0 = way_idx_t'(take_bits(3));
    s1 = set_idx_t'(take_bits(3));
    w1 = way_idx_t'(take_bits(3));
    if (s1 == s0 && w1 == w0) w1 = w1 + 1'b1;
    first = (last_grant + 1) % `LFILL_NUM_REQ;  // Round-robin winner
    fork
      run_miss(0, 0, s0, w0, FILL_ISSUED, st[0], dn[0]);
      run_miss(1, 0, s1, w1, FILL_ISSUED, st[1], dn[1]);
    join
    check_val("done_o latency", dn[first] - st[first], LAT + 2);
    check_val("done_o gap", dn[1-first] - dn[first], 1);
    close_test("different lines", e0);

    repeat (2) @(negedge clk);
    e0 = error_total();
    run_miss(1, 0, rep_s, rep_w, FILL_ISSUED, st[1], dn[1]);
    check_val("done_o[1] latency", dn[1] - st[1], LAT + 2);
    close_test("repeat after return", e0);

    repeat (2) @(negedge clk);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total());
    if (error_total() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verification/bank_fill_chk.sv
`include "lfill_params.svh"

module bank_fill_chk import lfill_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic [`LFILL_NUM_REQ-1:0]                miss_ready_i,
  input  logic [`LFILL_NUM_REQ-1:0]                done_i,
  input  logic [`LFILL_NUM_REQ-1:0]                grant_i,
  input  logic [`LFILL_NUM_REQ-1:0][1:0]           state_i,
  input  fill_cmd_t                                cmd_i,
  input  fill_rsp_t                                rsp_i,
  input  logic [`LFILL_SETS-1:0][`LFILL_WAYS-1:0]  inflight_q_i
);

  int fail_cnt = 0;

  logic [`LFILL_SETS-1:0][`LFILL_WAYS-1:0] rsp_mask;  // Line hit by the response
  logic [`LFILL_SETS-1:0][`LFILL_WAYS-1:0] cmd_mask;  // Line being issued

  always_comb begin
    for (int s = 0; s < `LFILL_SETS; s++) begin
      rsp_mask[s] = rsp_i.way & {`LFILL_WAYS{rsp_i.rvalid & rsp_i.set[s]}};
      cmd_mask[s] = cmd_i.way & {`LFILL_WAYS{cmd_i.valid & cmd_i.set[s]}};
    end
  end

  // ------------------------------------------------------------
  // Reset state, grant and array rules
  // ------------------------------------------------------------
  a_reset_state: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (inflight_q_i == '0) && (&miss_ready_i) && (done_i == '0))
    else begin
      $error("State after reset is not idle with a clear array");
      fail_cnt++;
    end

  a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grant_i))
    else begin
      $error("More than one grant in a cycle");
      fail_cnt++;
    end

  a_rsp_clears: assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_mask != '0) |=> ((inflight_q_i & $past(rsp_mask)) == '0))
    else begin
      $error("Response did not clear its in-flight bit");
      fail_cnt++;
    end

  a_no_double_issue: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_i.valid |-> ((inflight_q_i & cmd_mask) == '0))
    else begin
      $error("Fill issued to a line already in flight");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // Done pulses per requester
  // ------------------------------------------------------------
  for (genvar n = 0; n < `LFILL_NUM_REQ; n++) begin : gen_done
    a_done_from_wait: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i[n] |-> $past((state_i[n] == REQ_WAIT) || ((state_i[n] == REQ_ARB) && grant_i[n])))
      else begin
        $error("Done raised by a requester that was not waiting");
        fail_cnt++;
      end
  end

endmodule

// File: src/bank_fill_top.sv
`include "lfill_params.svh"

module bank_fill_top import lfill_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  miss_t        [`LFILL_NUM_REQ-1:0]    miss_i,
  output logic         [`LFILL_NUM_REQ-1:0]    miss_ready_o,
  output logic         [`LFILL_NUM_REQ-1:0]    done_o,
  output fill_status_e [`LFILL_NUM_REQ-1:0]    done_status_o
);

  fill_req_t [`LFILL_NUM_REQ-1:0] req;
  logic      [`LFILL_NUM_REQ-1:0] grant;
  fill_status_e                   grant_status;
  set_dcd_t                       lookup_set;
  way_dcd_t                       lookup_way;
  logic                           inflight;
  fill_cmd_t                      cmd;
  fill_rsp_t                      rsp;

  // ------------------------------------------------------------
  // Miss handlers
  // ------------------------------------------------------------
  for (genvar n = 0; n < `LFILL_NUM_REQ; n++) begin : gen_req
    fill_requester u_req (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .miss_i         (miss_i[n]),
      .miss_ready_o   (miss_ready_o[n]),
      .req_o          (req[n]),
      .grant_i        (grant[n]),
      .grant_status_i (grant_status),
      .rsp_i          (rsp),          // Broadcast to all
      .done_o         (done_o[n]),
      .done_status_o  (done_status_o[n])
    );
  end

  fill_arbiter u_arb (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req),
    .grant_o        (grant),
    .grant_status_o (grant_status),
    .lookup_set_o   (lookup_set),
    .lookup_way_o   (lookup_way),
    .inflight_i     (inflight),
    .cmd_o          (cmd)
  );

  bank_isu_inflight_array u_array (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .lookup_set_i     (lookup_set),
    .lookup_way_i     (lookup_way),
    .linefill_valid_i (cmd.valid),
    .inflight_o       (inflight),
    .rsp_i            (rsp)
  );

  fill_biu u_biu (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cmd_i (cmd),
    .rsp_o (rsp)
  );

endmodule

// File: src/fill_biu.sv
`include "lfill_params.svh"

module fill_biu import lfill_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  fill_cmd_t cmd_i,
  output fill_rsp_t rsp_o
);

  localparam int LAT = `LFILL_BIU_LATENCY;

  logic [LAT-1:0] valid_q;
  set_dcd_t       set_q [LAT];
  way_dcd_t       way_q [LAT];

  // ------------------------------------------------------------
  // Fixed-latency command pipeline
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= '0;  // Nothing outstanding
    end else begin
      valid_q[0] <= cmd_i.valid;
      for (int k = 1; k < LAT; k++) begin
        valid_q[k] <= valid_q[k-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    set_q[0] <= cmd_i.set;
    way_q[0] <= cmd_i.way;
    for (int k = 1; k < LAT; k++) begin
      set_q[k] <= set_q[k-1];
      way_q[k] <= way_q[k-1];
    end
  end

  // Last stage is the response
  assign rsp_o.rvalid = valid_q[LAT-1];
  assign rsp_o.set    = set_q[LAT-1];
  assign rsp_o.way    = way_q[LAT-1];

endmodule

// File: src/fill_arbiter.sv
`include "lfill_params.svh"

module fill_arbiter import lfill_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  fill_req_t [`LFILL_NUM_REQ-1:0]    req_i,
  output logic      [`LFILL_NUM_REQ-1:0]    grant_o,
  output fill_status_e                      grant_status_o,
  output set_dcd_t                          lookup_set_o,
  output way_dcd_t                          lookup_way_o,
  input  logic                              inflight_i,
  output fill_cmd_t                         cmd_o
);

  localparam int PTR_W = (`LFILL_NUM_REQ > 1) ? $clog2(`LFILL_NUM_REQ) : 1;

  logic [PTR_W-1:0] rr_q;  // First requester to consider
  logic [PTR_W-1:0] cand;
  logic [PTR_W-1:0] sel;
  logic             found;

  // ------------------------------------------------------------
  // Round-robin pick
  // ------------------------------------------------------------
  always_comb begin
    found = 1'b0;
    sel   = rr_q;
    cand  = rr_q;
    for (int i = 0; i < `LFILL_NUM_REQ; i++) begin
      cand = PTR_W'((int'(rr_q) + i) % `LFILL_NUM_REQ);
      if (!found && req_i[cand].valid) begin
        found = 1'b1;
        sel   = cand;
      end
    end
    grant_o = '0;
    if (found) grant_o[sel] = 1'b1;
  end

  assign lookup_set_o   = req_i[sel].set & {`LFILL_SETS{found}};
  assign lookup_way_o   = req_i[sel].way & {`LFILL_WAYS{found}};
  assign grant_status_o = inflight_i ? FILL_MERGED : FILL_ISSUED;

  // Issue only lines not already on the bus
  assign cmd_o.valid = found & ~inflight_i;
  assign cmd_o.set   = lookup_set_o;
  assign cmd_o.way   = lookup_way_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else if (found) begin
      rr_q <= PTR_W'((int'(sel) + 1) % `LFILL_NUM_REQ);  // Past the winner
    end
  end

endmodule

// File: src/fill_requester.sv
`include "lfill_params.svh"

module fill_requester import lfill_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  miss_t        miss_i,
  output logic         miss_ready_o,
  output fill_req_t    req_o,
  input  logic         grant_i,
  input  fill_status_e grant_status_i,
  input  fill_rsp_t    rsp_i,
  output logic         done_o,
  output fill_status_e done_status_o
);

  req_state_e   state_q;
  req_state_e   state_d;
  set_dcd_t     set_q;
  way_dcd_t     way_q;
  fill_status_e status_q;
  logic         accept;
  logic         rsp_hit;
  logic         finish;
  fill_status_e finish_status;

  assign miss_ready_o = (state_q == REQ_IDLE);
  assign accept       = miss_i.valid & miss_ready_o;
  assign rsp_hit      = rsp_i.rvalid & (rsp_i.set == set_q) & (rsp_i.way == way_q);

  assign req_o.valid = (state_q == REQ_ARB);
  assign req_o.set   = set_q;
  assign req_o.way   = way_q;

  // ------------------------------------------------------------
  // Miss FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    finish        = 1'b0;
    finish_status = status_q;
    case (state_q)
      REQ_IDLE: begin
        if (accept) state_d = REQ_ARB;
      end
      REQ_ARB: begin
        if (grant_i) begin
          finish_status = grant_status_i;
          if (rsp_hit) begin  // Merged onto the fill returning now
            finish  = 1'b1;
            state_d = REQ_IDLE;
          end else begin
            state_d = REQ_WAIT;
          end
        end
      end
      REQ_WAIT: begin
        if (rsp_hit) begin
          finish  = 1'b1;
          state_d = REQ_IDLE;
        end
      end
      default: state_d = REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q       <= REQ_IDLE;
      done_o        <= 1'b0;
      done_status_o <= FILL_ISSUED;
    end else begin
      state_q       <= state_d;
      done_o        <= finish;
      done_status_o <= finish_status;
    end
  end

  // Held line and grant status
  always_ff @(posedge clk_i) begin
    if (accept) begin
      set_q <= set_dcd_t'(1) << miss_i.set;
      way_q <= way_dcd_t'(1) << miss_i.way;
    end
    if (grant_i) status_q <= grant_status_i;
  end

endmodule

// File: src/bank_isu_inflight_array.sv
`include "lfill_params.svh"

module bank_isu_inflight_array import lfill_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  set_dcd_t  lookup_set_i,
  input  way_dcd_t  lookup_way_i,
  input  logic      linefill_valid_i,
  output logic      inflight_o,
  input  fill_rsp_t rsp_i
);

  logic [`LFILL_SETS-1:0][`LFILL_WAYS-1:0] inflight_q;
  logic [`LFILL_SETS-1:0][`LFILL_WAYS-1:0] inflight_d;
  logic [`LFILL_WAYS-1:0]                  row_sel;
  logic [`LFILL_WAYS-1:0]                  set_mask;
  logic [`LFILL_WAYS-1:0]                  clr_mask;

  // ------------------------------------------------------------
  // Per-set update and row read
  // ------------------------------------------------------------
  always_comb begin
    row_sel  = '0;
    set_mask = '0;
    clr_mask = '0;
    for (int s = 0; s < `LFILL_SETS; s++) begin
      set_mask = lookup_way_i & {`LFILL_WAYS{linefill_valid_i & lookup_set_i[s]}};
      clr_mask = rsp_i.way & {`LFILL_WAYS{rsp_i.rvalid & rsp_i.set[s]}};
      inflight_d[s] = set_mask | (inflight_q[s] & ~clr_mask);  // Set wins
      row_sel = row_sel | (inflight_q[s] & {`LFILL_WAYS{lookup_set_i[s]}});
    end
  end

  assign inflight_o = |(row_sel & lookup_way_i);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// File: src/lfill_pkg.sv
`include "lfill_params.svh"

package lfill_pkg;

  // ------------------------------------------------------------
  // Line selects
  // ------------------------------------------------------------
  typedef logic [`LFILL_SETS-1:0]         set_dcd_t;  // One-hot
  typedef logic [`LFILL_WAYS-1:0]         way_dcd_t;  // One-hot
  typedef logic [$clog2(`LFILL_SETS)-1:0] set_idx_t;
  typedef logic [$clog2(`LFILL_WAYS)-1:0] way_idx_t;

  // ------------------------------------------------------------
  // Path payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic     valid;
    set_idx_t set;
    way_idx_t way;
  } miss_t;

  typedef struct packed {
    logic     valid;
    set_dcd_t set;
    way_dcd_t way;
  } fill_req_t;

  typedef struct packed {
    logic     valid;  // Also the array's linefill valid
    set_dcd_t set;
    way_dcd_t way;
  } fill_cmd_t;

  typedef struct packed {
    logic     rvalid;
    set_dcd_t set;
    way_dcd_t way;
  } fill_rsp_t;

  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_ARB,
    REQ_WAIT
  } req_state_e;

  typedef enum logic {
    FILL_ISSUED,
    FILL_MERGED
  } fill_status_e;

endpackage

// File: src/lfill_params.svh
`ifndef LFILL_PARAMS_SVH
`define LFILL_PARAMS_SVH

// ------------------------------------------------------------
// Line-fill path sizes
// ------------------------------------------------------------

// Array geometry, fixes the one-hot decode widths
`define LFILL_SETS 8
`define LFILL_WAYS 8

// Miss handlers sharing the bus unit
`define LFILL_NUM_REQ 2

// Issue edge to response cycle
`define LFILL_BIU_LATENCY 4

`endif
